//--- source/motion_pkg.sv
`default_nettype none

package motion_pkg;

	localparam int n_stepdir = 2; // stepper channels.
	localparam int n_endstop = 2; // endstop channels.
	localparam int move_depth = 8; // moves per queue, a power of two.
	localparam int move_ptr_w = $clog2(move_depth);
	localparam int chan_w = $clog2(n_stepdir > n_endstop ? n_stepdir : n_endstop);

	typedef logic [31:0] time_t;
	typedef logic [31:0] interval_t;
	typedef logic [31:0] count_t;
	typedef logic signed [31:0] add_t;
	typedef logic signed [31:0] position_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0] cmd_t;
	typedef logic [chan_w-1:0] chan_t;
	typedef logic [23:0] sample_t;
	// packed as {dir, interval, count, add}.
	typedef logic [$bits(interval_t)+$bits(count_t)+$bits(add_t):0] move_t;

	localparam cmd_t cmd_config_stepper = 8'h10;
	localparam cmd_t cmd_queue_step = 8'h11;
	localparam cmd_t cmd_set_next_step_dir = 8'h12;
	localparam cmd_t cmd_reset_step_clock = 8'h13;
	localparam cmd_t cmd_stepper_get_pos = 8'h14;
	localparam cmd_t cmd_endstop_set_stepper = 8'h15;
	localparam cmd_t cmd_endstop_query = 8'h16;
	localparam cmd_t cmd_endstop_home = 8'h17;

	localparam word_t rsp_stepper_get_pos = 32'h0000_0030;
	localparam word_t rsp_endstop_state = 32'h0000_0031;

	typedef enum logic [4:0] {
		cs_idle, cs_config, cs_queue_interval, cs_queue_count, cs_queue_add,
		cs_set_dir, cs_reset_clock, cs_get_pos, cs_get_pos_rsp, cs_set_stepper,
		cs_query_homing, cs_query_pin, cs_query_rsp,
		cs_home_time, cs_home_samples, cs_home_pin, cs_wait_grant
	} cmd_state_e;

	typedef enum logic [1:0] {
		hs_idle, hs_wait_clock, hs_rest, hs_sample
	} homing_state_e;

endpackage

`default_nettype wire

//--- source/move_queue.sv
`timescale 1ns/100ps
`default_nettype none

module move_queue (
	input wire clk,
	input wire rst,
	input wire wr,
	input wire motion_pkg::move_t wr_data,
	input wire pop,
	input wire flush,
	output motion_pkg::move_t rd_data,
	output logic not_empty
);

	motion_pkg::move_t mem [motion_pkg::move_depth];
	logic [motion_pkg::move_ptr_w-1:0] wr_ptr;
	logic [motion_pkg::move_ptr_w-1:0] rd_ptr;
	logic [motion_pkg::move_ptr_w:0] used; // occupancy, one bit wider than the pointers.
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = used[motion_pkg::move_ptr_w]; // set only at move_depth.
	assign not_empty = used != '0;
	assign do_wr = wr && !full; // a write into a full queue is lost.
	assign do_rd = pop && not_empty;
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: ; // both or neither leaves the count.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

`default_nettype wire

//--- source/step_generator.sv
`timescale 1ns/100ps
`default_nettype none

module step_generator (
	input wire clk,
	input wire rst,
	input wire motion_pkg::time_t systime,
	input wire motion_pkg::move_t move,
	input wire not_empty,
	output logic pop,
	input wire stop,
	input wire dedge,
	input wire clock_load,
	input wire motion_pkg::time_t clock_value,
	output logic step,
	output logic dir,
	output motion_pkg::position_t position
);

	logic active;
	logic fire;
	motion_pkg::time_t last_time;
	motion_pkg::time_t target;
	motion_pkg::interval_t interval;
	motion_pkg::count_t count;
	motion_pkg::add_t add;

	// the next step falls one interval after the previous one.
	assign target = last_time + interval;
	assign fire = active && (systime == target);
	assign pop = !active && not_empty && !stop;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			step <= 1'b0;
			dir <= 1'b0;
			position <= '0;
		end else if (stop) begin
			active <= 1'b0; // position is kept.
			step <= 1'b0;
		end else begin
			if (pop) begin
				active <= move[63:32] != '0; // zero count, nothing to do.
				dir <= move[96];
			end
			if (fire) begin
				step <= dedge ? !step : 1'b1;
				if (dir)
					position <= position + 32'sd1;
				else
					position <= position - 32'sd1;
				if (count == 32'd1)
					active <= 1'b0; // last step of this move.
			end else if (!dedge) begin
				step <= 1'b0; // pulse mode, high for one cycle.
			end
		end
	end

	// step clock reference.
	always_ff @(posedge clk) begin
		if (rst)
			last_time <= '0;
		else if (clock_load)
			last_time <= clock_value;
		else if (fire)
			last_time <= target;
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			interval <= move[95:64];
			count <= move[63:32];
			add <= move[31:0];
		end else if (fire) begin
			interval <= interval + motion_pkg::interval_t'(add); // add may be negative.
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/endstop_homing.sv
`timescale 1ns/100ps
`default_nettype none

module endstop_homing (
	input wire clk,
	input wire rst,
	input wire motion_pkg::time_t systime,
	input wire pin,
	input wire arm,
	input wire motion_pkg::time_t arm_time,
	input wire motion_pkg::sample_t arm_samples,
	input wire arm_pin,
	output logic homing,
	output logic triggered
);

	motion_pkg::homing_state_e state;
	motion_pkg::time_t start_time;
	motion_pkg::sample_t samples;
	motion_pkg::sample_t remaining;
	logic want_pin;

	assign homing = state != motion_pkg::hs_idle;

	always_ff @(posedge clk) begin
		if (arm) begin
			start_time <= arm_time;
			samples <= arm_samples;
			want_pin <= arm_pin;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= motion_pkg::hs_idle;
			triggered <= 1'b0;
		end else begin
			triggered <= 1'b0;
			if (arm) begin
				// zero samples cancels homing.
				if (arm_samples == '0)
					state <= motion_pkg::hs_idle;
				else
					state <= motion_pkg::hs_wait_clock;
			end else begin
				case (state)
					motion_pkg::hs_wait_clock:
						if (systime == start_time)
							state <= motion_pkg::hs_rest;
					motion_pkg::hs_rest:
						if (pin == want_pin) begin
							state <= motion_pkg::hs_sample;
							remaining <= samples;
						end
					motion_pkg::hs_sample:
						if (pin != want_pin) begin
							state <= motion_pkg::hs_rest; // bounce, start over.
						end else if (remaining == 24'd1) begin
							state <= motion_pkg::hs_idle;
							triggered <= 1'b1;
						end else begin
							remaining <= remaining - 1'b1;
						end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- source/stepper_cmd.sv
`timescale 1ns/100ps
`default_nettype none

module stepper_cmd (
	input wire clk,
	input wire rst,
	input wire motion_pkg::cmd_t cmd,
	input wire cmd_ready,
	input wire motion_pkg::word_t arg_data,
	output logic cmd_done,
	output motion_pkg::word_t param_data,
	output logic param_write,
	output logic invol_req,
	input wire invol_grant,
	input wire [motion_pkg::n_endstop-1:0] endstop,
	input wire shutdown,
	output logic [motion_pkg::n_stepdir-1:0] move_wr,
	output motion_pkg::move_t move_word,
	output logic [motion_pkg::n_stepdir-1:0] dedge,
	output logic [motion_pkg::n_stepdir-1:0] clock_load,
	output motion_pkg::time_t clock_value,
	input wire motion_pkg::position_t position [motion_pkg::n_stepdir],
	output logic [motion_pkg::n_endstop-1:0] arm,
	output motion_pkg::time_t arm_time,
	output motion_pkg::sample_t arm_samples,
	output logic arm_pin,
	input wire [motion_pkg::n_endstop-1:0] homing,
	input wire [motion_pkg::n_endstop-1:0] triggered,
	output logic [motion_pkg::n_stepdir-1:0] stop
);

	motion_pkg::cmd_state_e state;
	motion_pkg::chan_t channel;
	motion_pkg::chan_t report_chan;
	logic [motion_pkg::n_stepdir-1:0] next_dir;
	logic [motion_pkg::n_stepdir-1:0] link [motion_pkg::n_endstop]; // steppers per endstop.
	logic [motion_pkg::n_endstop-1:0] pending; // reports waiting for a grant.
	motion_pkg::interval_t q_interval;
	motion_pkg::count_t q_count;
	motion_pkg::add_t q_add;

	assign move_word = {next_dir[channel], q_interval, q_count, q_add};

	// lowest pending endstop wins.
	always_comb begin
		report_chan = '0;
		for (int i = motion_pkg::n_endstop - 1; i >= 0; i--)
			if (pending[i])
				report_chan = motion_pkg::chan_t'(i);
	end

	always_comb begin
		stop = {motion_pkg::n_stepdir{shutdown}};
		for (int i = 0; i < motion_pkg::n_endstop; i++)
			if (triggered[i])
				stop = stop | link[i];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= motion_pkg::cs_idle;
			channel <= '0;
			cmd_done <= 1'b0;
			param_write <= 1'b0;
			param_data <= '0;
			invol_req <= 1'b0;
			move_wr <= '0;
			clock_load <= '0;
			arm <= '0;
			dedge <= '0;
			next_dir <= '0;
			pending <= '0;
			for (int i = 0; i < motion_pkg::n_endstop; i++)
				link[i] <= '0;
		end else begin
			cmd_done <= 1'b0;
			move_wr <= '0;
			clock_load <= '0;
			arm <= '0;
			case (state)
				motion_pkg::cs_idle:
					if (cmd_ready) begin
						channel <= arg_data[motion_pkg::chan_w-1:0]; // first arg is always the channel.
						case (cmd)
							motion_pkg::cmd_config_stepper: state <= motion_pkg::cs_config;
							motion_pkg::cmd_queue_step: state <= motion_pkg::cs_queue_interval;
							motion_pkg::cmd_set_next_step_dir: state <= motion_pkg::cs_set_dir;
							motion_pkg::cmd_reset_step_clock: state <= motion_pkg::cs_reset_clock;
							motion_pkg::cmd_stepper_get_pos: state <= motion_pkg::cs_get_pos;
							motion_pkg::cmd_endstop_set_stepper: state <= motion_pkg::cs_set_stepper;
							motion_pkg::cmd_endstop_query: state <= motion_pkg::cs_query_homing;
							motion_pkg::cmd_endstop_home: state <= motion_pkg::cs_home_time;
							default: cmd_done <= 1'b1; // unknown code, just finish.
						endcase
					end else if (|pending) begin
						invol_req <= 1'b1;
						state <= motion_pkg::cs_wait_grant;
					end
				motion_pkg::cs_wait_grant:
					if (invol_grant) begin
						invol_req <= 1'b0;
						channel <= report_chan;
						pending[report_chan] <= 1'b0;
						state <= motion_pkg::cs_query_homing;
					end
				motion_pkg::cs_config: begin
					dedge[channel] <= arg_data[0];
					cmd_done <= 1'b1;
					state <= motion_pkg::cs_idle;
				end
				motion_pkg::cs_queue_interval: begin
					q_interval <= arg_data;
					state <= motion_pkg::cs_queue_count;
				end
				motion_pkg::cs_queue_count: begin
					q_count <= arg_data;
					state <= motion_pkg::cs_queue_add;
				end
				motion_pkg::cs_queue_add: begin
					q_add <= arg_data;
					move_wr[channel] <= 1'b1;
					cmd_done <= 1'b1;
					state <= motion_pkg::cs_idle;
				end
				motion_pkg::cs_set_dir: begin
					next_dir[channel] <= arg_data[0];
					cmd_done <= 1'b1;
					state <= motion_pkg::cs_idle;
				end
				motion_pkg::cs_reset_clock: begin
					clock_value <= arg_data;
					clock_load[channel] <= 1'b1;
					cmd_done <= 1'b1;
					state <= motion_pkg::cs_idle;
				end
				motion_pkg::cs_get_pos: begin
					param_data <= position[channel];
					param_write <= 1'b1;
					state <= motion_pkg::cs_get_pos_rsp;
				end
				motion_pkg::cs_get_pos_rsp: begin
					param_write <= 1'b0;
					param_data <= motion_pkg::rsp_stepper_get_pos;
					cmd_done <= 1'b1;
					state <= motion_pkg::cs_idle;
				end
				motion_pkg::cs_set_stepper: begin
					link[channel][arg_data[motion_pkg::chan_w-1:0]] <= 1'b1;
					cmd_done <= 1'b1;
					state <= motion_pkg::cs_idle;
				end
				// shared by the query command and the unsolicited report.
				motion_pkg::cs_query_homing: begin
					param_data <= motion_pkg::word_t'(homing[channel]);
					param_write <= 1'b1;
					state <= motion_pkg::cs_query_pin;
				end
				motion_pkg::cs_query_pin: begin
					param_data <= motion_pkg::word_t'(endstop[channel]); // live pin level.
					state <= motion_pkg::cs_query_rsp;
				end
				motion_pkg::cs_query_rsp: begin
					param_write <= 1'b0;
					param_data <= motion_pkg::rsp_endstop_state;
					cmd_done <= 1'b1;
					state <= motion_pkg::cs_idle;
				end
				motion_pkg::cs_home_time: begin
					arm_time <= arg_data;
					state <= motion_pkg::cs_home_samples;
				end
				motion_pkg::cs_home_samples: begin
					arm_samples <= arg_data[$bits(motion_pkg::sample_t)-1:0];
					state <= motion_pkg::cs_home_pin;
				end
				motion_pkg::cs_home_pin: begin
					arm_pin <= arg_data[0];
					arm[channel] <= 1'b1; // engine sees all three values with this strobe.
					cmd_done <= 1'b1;
					state <= motion_pkg::cs_idle;
				end
				default: state <= motion_pkg::cs_idle;
			endcase
			// a new trigger outranks the clear above.
			for (int i = 0; i < motion_pkg::n_endstop; i++)
				if (triggered[i])
					pending[i] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/motion_top.sv
`timescale 1ns/100ps
`default_nettype none

module motion_top (
	input wire clk,
	input wire rst,
	input wire motion_pkg::time_t systime,
	input wire motion_pkg::cmd_t cmd,
	input wire cmd_ready,
	input wire motion_pkg::word_t arg_data,
	output logic cmd_done,
	output motion_pkg::word_t param_data,
	output logic param_write,
	output logic invol_req,
	input wire invol_grant,
	output logic [motion_pkg::n_stepdir-1:0] step,
	output logic [motion_pkg::n_stepdir-1:0] dir,
	input wire [motion_pkg::n_endstop-1:0] endstop,
	input wire shutdown
);

	logic [motion_pkg::n_stepdir-1:0] move_wr;
	motion_pkg::move_t move_word;
	logic [motion_pkg::n_stepdir-1:0] dedge;
	logic [motion_pkg::n_stepdir-1:0] clock_load;
	motion_pkg::time_t clock_value;
	motion_pkg::position_t position [motion_pkg::n_stepdir];
	logic [motion_pkg::n_stepdir-1:0] stop;
	motion_pkg::move_t q_data [motion_pkg::n_stepdir];
	logic [motion_pkg::n_stepdir-1:0] q_not_empty;
	logic [motion_pkg::n_stepdir-1:0] q_pop;
	logic [motion_pkg::n_endstop-1:0] arm;
	motion_pkg::time_t arm_time;
	motion_pkg::sample_t arm_samples;
	logic arm_pin;
	logic [motion_pkg::n_endstop-1:0] homing;
	logic [motion_pkg::n_endstop-1:0] triggered;

	stepper_cmd u_cmd (
		.clk(clk), .rst(rst),
		.cmd(cmd), .cmd_ready(cmd_ready), .arg_data(arg_data), .cmd_done(cmd_done),
		.param_data(param_data), .param_write(param_write),
		.invol_req(invol_req), .invol_grant(invol_grant),
		.endstop(endstop), .shutdown(shutdown),
		.move_wr(move_wr), .move_word(move_word), .dedge(dedge),
		.clock_load(clock_load), .clock_value(clock_value), .position(position),
		.arm(arm), .arm_time(arm_time), .arm_samples(arm_samples), .arm_pin(arm_pin),
		.homing(homing), .triggered(triggered), .stop(stop)
	);

	// one queue and generator per stepper; every queue sees the same move word.
	for (genvar g = 0; g < motion_pkg::n_stepdir; g++) begin : g_stepper
		move_queue u_queue (
			.clk(clk), .rst(rst),
			.wr(move_wr[g]), .wr_data(move_word),
			.pop(q_pop[g]), .flush(stop[g]),
			.rd_data(q_data[g]), .not_empty(q_not_empty[g])
		);

		step_generator u_gen (
			.clk(clk), .rst(rst), .systime(systime),
			.move(q_data[g]), .not_empty(q_not_empty[g]), .pop(q_pop[g]),
			.stop(stop[g]), .dedge(dedge[g]),
			.clock_load(clock_load[g]), .clock_value(clock_value),
			.step(step[g]), .dir(dir[g]), .position(position[g])
		);
	end

	for (genvar e = 0; e < motion_pkg::n_endstop; e++) begin : g_endstop
		endstop_homing u_homing (
			.clk(clk), .rst(rst), .systime(systime), .pin(endstop[e]),
			.arm(arm[e]), .arm_time(arm_time), .arm_samples(arm_samples), .arm_pin(arm_pin),
			.homing(homing[e]), .triggered(triggered[e])
		);
	end

endmodule

`default_nettype wire

//--- tests/tb_motion.sv
`timescale 1ns/100ps
`default_nettype none

module tb_motion;

	localparam int cmd_timeout = 50;
	localparam int step_timeout = 200;
	localparam int invol_timeout = 50;

	logic clk = 1'b0;
	logic rst;
	motion_pkg::time_t systime;
	motion_pkg::cmd_t cmd;
	logic cmd_ready;
	motion_pkg::word_t arg_data;
	logic cmd_done;
	motion_pkg::word_t param_data;
	logic param_write;
	logic invol_req;
	logic invol_grant;
	logic [motion_pkg::n_stepdir-1:0] step;
	logic [motion_pkg::n_stepdir-1:0] dir;
	logic [motion_pkg::n_endstop-1:0] endstop;
	logic shutdown;

	int errors = 0;
	int timeouts = 0;
	motion_pkg::word_t params [$]; // words seen with param_write in the last response.
	motion_pkg::word_t rsp; // param_data when cmd_done was seen.

	motion_top u_dut (
		.clk(clk), .rst(rst), .systime(systime),
		.cmd(cmd), .cmd_ready(cmd_ready), .arg_data(arg_data), .cmd_done(cmd_done),
		.param_data(param_data), .param_write(param_write),
		.invol_req(invol_req), .invol_grant(invol_grant),
		.step(step), .dir(dir), .endstop(endstop), .shutdown(shutdown)
	);

	always #50 clk = ~clk;

	// one clock; inputs change and outputs are read 10 ns after the edge.
	task automatic tick();
		@(posedge clk);
		#10;
		systime = systime + 1;
	endtask

	task automatic check_word(input string name, input motion_pkg::word_t exp,
			input motion_pkg::word_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_position(input string name, input motion_pkg::position_t exp,
			input motion_pkg::position_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_time(input string name, input motion_pkg::time_t exp,
			input motion_pkg::time_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	// channel goes first and the rest follow one per clock.
	task automatic issue_cmd(input motion_pkg::cmd_t code, input int n,
			input motion_pkg::word_t args [4]);
		cmd = code;
		cmd_ready = 1'b1;
		arg_data = args[0];
		for (int i = 1; i < n; i++) begin
			tick();
			cmd_ready = 1'b0;
			arg_data = args[i];
		end
	endtask

	// also collects an unsolicited report. the grant drops after one edge.
	task automatic finish_cmd();
		int n;
		params.delete();
		for (n = 0; n < cmd_timeout; n++) begin
			tick();
			cmd_ready = 1'b0;
			invol_grant = 1'b0;
			arg_data = '0;
			if (param_write)
				params.push_back(param_data);
			if (cmd_done)
				break;
		end
		rsp = param_data;
		if (n == cmd_timeout) begin
			$display("timeout: cmd_done never came for command %h", cmd);
			timeouts++;
		end
	endtask

	task automatic run_cmd(input motion_pkg::cmd_t code, input int n,
			input motion_pkg::word_t args [4]);
		issue_cmd(code, n, args);
		finish_cmd();
		check_word("param_write count", 32'd0, motion_pkg::word_t'(params.size()));
	endtask

	task automatic read_pos(input motion_pkg::chan_t ch, output motion_pkg::position_t p);
		issue_cmd(motion_pkg::cmd_stepper_get_pos, 1, '{motion_pkg::word_t'(ch), 0, 0, 0});
		finish_cmd();
		check_word("param_write count", 32'd1, motion_pkg::word_t'(params.size()));
		check_word("param_data response", motion_pkg::rsp_stepper_get_pos, rsp);
		p = params.size() > 0 ? motion_pkg::position_t'(params[0]) : 'x;
	endtask

	task automatic check_report(input logic exp_homing, input logic exp_pin);
		check_word("param_write count", 32'd2, motion_pkg::word_t'(params.size()));
		if (params.size() == 2) begin
			check_word("param_data homing", motion_pkg::word_t'(exp_homing), params[0]);
			check_word("param_data pin", motion_pkg::word_t'(exp_pin), params[1]);
		end
		check_word("param_data response", motion_pkg::rsp_endstop_state, rsp);
	endtask

	// step clock reference a little ahead, so the queued move is in place first.
	task automatic start_clock(input motion_pkg::chan_t ch, output motion_pkg::time_t t0);
		t0 = systime + 30;
		run_cmd(motion_pkg::cmd_reset_step_clock, 2, '{motion_pkg::word_t'(ch), t0, 0, 0});
	endtask

	task automatic wait_step(input motion_pkg::chan_t ch, input logic toggle,
			output motion_pkg::time_t seen);
		logic prev;
		int n;
		prev = step[ch];
		for (n = 0; n < step_timeout; n++) begin
			tick();
			if (toggle ? (step[ch] != prev) : (step[ch] == 1'b1))
				break;
		end
		seen = systime;
		if (n == step_timeout) begin
			$display("timeout: no step seen on channel %0d", ch);
			timeouts++;
		end
	endtask

	task automatic wait_invol();
		int n;
		for (n = 0; n < invol_timeout; n++) begin
			tick();
			if (invol_req)
				break;
		end
		if (n == invol_timeout) begin
			$display("timeout: invol_req never rose after the endstop trigger");
			timeouts++;
		end
	endtask

	task automatic count_steps(input motion_pkg::chan_t ch, input int cycles, output int n);
		n = 0;
		repeat (cycles) begin
			tick();
			if (step[ch])
				n++;
		end
	endtask

	task automatic reset_values();
		motion_pkg::position_t p;
		check_bit("step[0]", 1'b0, step[0]);
		check_bit("step[1]", 1'b0, step[1]);
		check_bit("cmd_done", 1'b0, cmd_done);
		check_bit("invol_req", 1'b0, invol_req);
		check_bit("param_write", 1'b0, param_write);
		read_pos(1'b0, p);
		check_position("position[0]", 32'sd0, p);
		read_pos(1'b1, p);
		check_position("position[1]", 32'sd0, p);
		run_cmd(8'hee, 1, '{0, 0, 0, 0}); // not a known code.
	endtask

	task automatic timed_stepping();
		motion_pkg::time_t t0;
		motion_pkg::time_t seen;
		motion_pkg::position_t p;
		start_clock(1'b0, t0);
		run_cmd(motion_pkg::cmd_set_next_step_dir, 2, '{0, 1, 0, 0});
		run_cmd(motion_pkg::cmd_queue_step, 4, '{0, 10, 3, 2});
		// intervals 10, 12, 14; seen one tick after each target.
		wait_step(1'b0, 1'b0, seen);
		check_time("systime at step 1", t0 + 11, seen);
		wait_step(1'b0, 1'b0, seen);
		check_time("systime at step 2", t0 + 23, seen);
		wait_step(1'b0, 1'b0, seen);
		check_time("systime at step 3", t0 + 37, seen);
		check_bit("dir[0]", 1'b1, dir[0]);
		read_pos(1'b0, p);
		check_position("position[0]", 32'sd3, p);
		start_clock(1'b0, t0);
		run_cmd(motion_pkg::cmd_set_next_step_dir, 2, '{0, 0, 0, 0});
		run_cmd(motion_pkg::cmd_queue_step, 4, '{0, 10, 2, 0});
		wait_step(1'b0, 1'b0, seen);
		check_time("systime at step 1", t0 + 11, seen);
		wait_step(1'b0, 1'b0, seen);
		check_time("systime at step 2", t0 + 21, seen);
		check_bit("dir[0]", 1'b0, dir[0]);
		read_pos(1'b0, p);
		check_position("position[0]", 32'sd1, p);
	endtask

	task automatic toggle_stepping();
		motion_pkg::time_t t0;
		motion_pkg::time_t seen;
		motion_pkg::position_t p;
		logic level;
		run_cmd(motion_pkg::cmd_config_stepper, 2, '{0, 1, 0, 0});
		run_cmd(motion_pkg::cmd_set_next_step_dir, 2, '{0, 1, 0, 0});
		start_clock(1'b0, t0);
		level = step[0];
		run_cmd(motion_pkg::cmd_queue_step, 4, '{0, 10, 4, 0});
		for (int i = 0; i < 4; i++) begin
			wait_step(1'b0, 1'b1, seen);
			check_time("systime at toggle", t0 + 11 + 10 * i, seen);
		end
		repeat (15)
			tick(); // past the slot of a fifth step.
		check_bit("step[0]", level, step[0]); // even number of toggles.
		read_pos(1'b0, p);
		check_position("position[0]", 32'sd5, p);
		run_cmd(motion_pkg::cmd_config_stepper, 2, '{0, 0, 0, 0});
	endtask

	task automatic endstop_queries();
		endstop = 2'b01;
		issue_cmd(motion_pkg::cmd_endstop_query, 1, '{0, 0, 0, 0});
		finish_cmd();
		check_report(1'b0, 1'b1);
		endstop = 2'b00;
		issue_cmd(motion_pkg::cmd_endstop_query, 1, '{0, 0, 0, 0});
		finish_cmd();
		check_report(1'b0, 1'b0);
		endstop = 2'b10;
		issue_cmd(motion_pkg::cmd_endstop_query, 1, '{1, 0, 0, 0});
		finish_cmd();
		check_report(1'b0, 1'b1);
		endstop = 2'b00;
	endtask

	task automatic homing_report();
		motion_pkg::time_t t0;
		motion_pkg::time_t seen;
		motion_pkg::position_t p;
		int n;
		run_cmd(motion_pkg::cmd_endstop_set_stepper, 2, '{0, 0, 0, 0});
		run_cmd(motion_pkg::cmd_set_next_step_dir, 2, '{0, 1, 0, 0});
		start_clock(1'b0, t0);
		run_cmd(motion_pkg::cmd_queue_step, 4, '{0, 10, 1000, 0});
		run_cmd(motion_pkg::cmd_endstop_home, 4, '{0, systime + 8, 3, 1});
		wait_step(1'b0, 1'b0, seen);
		endstop = 2'b01; // pin reaches the wanted level while moving.
		wait_invol();
		repeat (6)
			tick();
		check_bit("invol_req", 1'b1, invol_req);
		invol_grant = 1'b1;
		finish_cmd();
		check_report(1'b0, 1'b1);
		check_bit("invol_req", 1'b0, invol_req);
		read_pos(1'b0, p);
		check_position("position[0]", 32'sd6, p); // one step before the trigger.
		count_steps(1'b0, 100, n);
		check_word("step[0] pulses after trigger", 32'd0, motion_pkg::word_t'(n));
		read_pos(1'b0, p);
		check_position("position[0]", 32'sd6, p);
		// zero samples only disarms.
		run_cmd(motion_pkg::cmd_endstop_home, 4, '{0, systime + 8, 0, 1});
		n = 0;
		repeat (60) begin
			tick();
			if (invol_req)
				n++;
		end
		check_word("invol_req cycles", 32'd0, motion_pkg::word_t'(n));
		issue_cmd(motion_pkg::cmd_endstop_query, 1, '{0, 0, 0, 0});
		finish_cmd();
		check_report(1'b0, 1'b1);
		endstop = 2'b00;
	endtask

	task automatic shutdown_hold();
		motion_pkg::time_t t0;
		motion_pkg::time_t t1;
		motion_pkg::time_t seen;
		motion_pkg::position_t p;
		int n;
		start_clock(1'b1, t1);
		start_clock(1'b0, t0);
		run_cmd(motion_pkg::cmd_set_next_step_dir, 2, '{1, 1, 0, 0});
		run_cmd(motion_pkg::cmd_queue_step, 4, '{1, 10, 20, 0});
		run_cmd(motion_pkg::cmd_queue_step, 4, '{0, 10, 20, 0});
		wait_step(1'b1, 1'b0, seen);
		check_time("systime at channel 1 step", t1 + 11, seen);
		check_bit("dir[1]", 1'b1, dir[1]);
		wait_step(1'b0, 1'b0, seen);
		check_time("systime at channel 0 step", t0 + 11, seen);
		shutdown = 1'b1;
		count_steps(1'b0, 30, n);
		check_word("step[0] pulses in shutdown", 32'd0, motion_pkg::word_t'(n));
		count_steps(1'b1, 30, n);
		check_word("step[1] pulses in shutdown", 32'd0, motion_pkg::word_t'(n));
		read_pos(1'b0, p);
		check_position("position[0]", 32'sd7, p);
		read_pos(1'b1, p);
		check_position("position[1]", 32'sd1, p);
		shutdown = 1'b0;
		count_steps(1'b0, 30, n);
		check_word("step[0] pulses after release", 32'd0, motion_pkg::word_t'(n));
		read_pos(1'b0, p);
		check_position("position[0]", 32'sd7, p);
		start_clock(1'b0, t0);
		run_cmd(motion_pkg::cmd_queue_step, 4, '{0, 10, 3, 0});
		repeat (3)
			wait_step(1'b0, 1'b0, seen);
		read_pos(1'b0, p);
		check_position("position[0]", 32'sd10, p);
	endtask

	initial begin
		rst = 1'b1;
		systime = '0;
		cmd = '0;
		cmd_ready = 1'b0;
		arg_data = '0;
		invol_grant = 1'b0;
		endstop = '0;
		shutdown = 1'b0;
		tick();
		tick();
		rst = 1'b0;
		tick();
		reset_values();
		timed_stepping();
		toggle_stepping();
		endstop_queries();
		homing_report();
		shutdown_hold();
		$display("closing: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
source/motion_pkg.sv
source/move_queue.sv
source/step_generator.sv
source/endstop_homing.sv
source/stepper_cmd.sv
source/motion_top.sv
tests/tb_motion.sv

//--- Makefile
# Verilator build for the motion-control block.

VERILATOR ?= verilator
TB_TOP ?= tb_motion
RTL_TOP ?= motion_top
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing
PASS_TEXT ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
